/* include/norm_defines.svh */
//////////////////////////////////////////////////
// Field widths for the FP32/FP16 normalize and round path
// FP64 and FP16ALT are not supported
// Datapath is sized for FP32 and FP16 sits in its top bits
//////////////////////////////////////////////////

`ifndef NORM_DEFINES_SVH
`define NORM_DEFINES_SVH

//////////////////////////////////////////////////
// Format fields

`define NORM_MANT_FP32 23  // FP32 fraction bits
`define NORM_EXP_FP32  8   // FP32 exponent bits

`define NORM_MANT_FP16 10  // FP16 fraction bits
`define NORM_EXP_FP16  5   // FP16 exponent bits

//////////////////////////////////////////////////
// Datapath

// Extra low significand bits delivered by the divider
`define NORM_GUARD_W 4

`define NORM_FLEN 32  // Result word

// Upper half of a boxed FP16 result
`define NORM_BOX_FILL 16'hffff

// FP16 fraction LSB inside the FP32 aligned significand
`define NORM_FP16_LSB (`NORM_MANT_FP32 - `NORM_MANT_FP16)

`endif

/* design/norm_pkg.sv */
//////////////////////////////////////////////////
// Types shared by the normalize and round stages
// Significands are FP32 aligned and FP16 uses the top 11 bits
// Rounding mode codes follow the RISC-V frm encoding
//////////////////////////////////////////////////

`include "norm_defines.svh"

package norm_pkg;

  //////////////////////////////////////////////////
  // Vector types

  // Top bit weighs 1.0
  typedef logic [`NORM_MANT_FP32+`NORM_GUARD_W:0] mant_in_t;
  typedef logic signed [`NORM_EXP_FP32+1:0] exp_in_t;  // Biased, with headroom
  typedef logic [`NORM_MANT_FP32:0] mant_t;            // Hidden bit on top
  typedef logic [`NORM_EXP_FP32-1:0] exp_t;            // Packed exponent
  typedef logic [`NORM_MANT_FP32+`NORM_GUARD_W:0] round_bits_t;
  typedef logic [`NORM_FLEN-1:0] flen_t;

  //////////////////////////////////////////////////
  // Enums

  typedef enum logic {FMT_FP32 = 1'b0, FMT_FP16 = 1'b1} fmt_e;

  typedef enum logic {OP_DIV = 1'b0, OP_SQRT = 1'b1} op_e;

  // Unlisted codes truncate
  typedef enum logic [2:0] {
    RM_RNE = 3'b000,
    RM_RTZ = 3'b001,
    RM_RDN = 3'b010,
    RM_RUP = 3'b011
  } rm_e;

  //////////////////////////////////////////////////
  // Structs

  typedef struct packed {
    logic nv;  // Invalid
    logic dz;  // Divide by zero
    logic of;  // Overflow
    logic uf;  // Underflow
    logic nx;  // Inexact
  } fflags_t;

  // Request from the divide/sqrt core
  typedef struct packed {
    mant_in_t mant;
    exp_in_t  exp;
    logic     sign;
    op_e      op;
    logic     nan_a;
    logic     nan_b;
    logic     snan;
    logic     inf_a;
    logic     inf_b;
    logic     zero_a;
    logic     zero_b;
    rm_e      rm;
    fmt_e     fmt;
  } norm_req_t;

  // Between stage one and stage two
  typedef struct packed {
    mant_t       mant;
    exp_t        exp;
    round_bits_t round_bits;  // Below mant LSB
    logic        sign;
    logic        special;     // Final value, skip rounding
    rm_e         rm;
    fmt_e        fmt;
    fflags_t     flags;
  } norm_mid_t;

endpackage

/* design/special_case_norm.sv */
//////////////////////////////////////////////////
// Stage one of normalize and round
// Special results leave already packed with special set
// Denormals are right shifted to exponent 0 here
// One cycle latency and no back-pressure
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "norm_defines.svh"

module special_case_norm
  import norm_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      in_valid,
  input  norm_req_t req,
  output logic      mid_valid,
  output norm_mid_t mid
);

  localparam int SHIFT_W  = $bits(mant_t) + $bits(round_bits_t);  // 52
  localparam int SIG_FP32 = `NORM_MANT_FP32 + 1;
  localparam int SIG_FP16 = `NORM_MANT_FP16 + 1;
  localparam int RS_W     = $clog2(SIG_FP32 + 1);  // Enough for a 24 bit shift
  localparam int CNT_W    = $bits(exp_in_t) + 1;

  // Quiet NaN has only the top fraction bit
  localparam mant_t QNAN_MANT = mant_t'(1) << (`NORM_MANT_FP32 - 1);

  logic                    is_div;
  logic                    is_sqrt;
  logic                    top_bit;       // 1.x versus 0.1x
  logic                    denorm;
  exp_in_t                 exp_max;       // All ones for the target format
  exp_in_t                 exp_dec;
  logic signed [CNT_W-1:0] rs_count;      // Right shifts to reach exponent 0
  logic signed [CNT_W-1:0] sig_w;         // Format significand width
  logic [SHIFT_W-1:0]      base_vec;
  logic [SHIFT_W-1:0]      rs_vec;
  logic [SHIFT_W-1:0]      norm_vec;
  norm_mid_t               mid_d;

  //////////////////////////////////////////////////
  // Classification helpers

  assign is_div  = (req.op == OP_DIV);
  assign is_sqrt = (req.op == OP_SQRT);
  assign top_bit = req.mant[$bits(mant_in_t)-1];

  assign exp_max = (req.fmt == FMT_FP32) ? exp_in_t'(2**`NORM_EXP_FP32 - 1)
                                         : exp_in_t'(2**`NORM_EXP_FP16 - 1);
  assign sig_w   = (req.fmt == FMT_FP32) ? CNT_W'(SIG_FP32) : CNT_W'(SIG_FP16);
  assign exp_dec = req.exp - exp_in_t'(1);

  // Exp <= 0, or exp 1 still below 1.0
  assign denorm = (req.exp <= exp_in_t'(0)) ||
                  ((req.exp == exp_in_t'(1)) && !top_bit);

  // 1 - exp, sign extended
  assign rs_count = CNT_W'(1) - CNT_W'(req.exp);

  // Input at top, room below for shifted-out bits
  assign base_vec = {req.mant, {$bits(mant_t){1'b0}}};
  assign rs_vec   = base_vec >> rs_count[RS_W-1:0];
  assign norm_vec = top_bit ? base_vec : (base_vec << 1);

  //////////////////////////////////////////////////
  // Priority chain

  always_comb
  begin
    mid_d         = '0;
    mid_d.sign    = req.sign;
    mid_d.rm      = req.rm;
    mid_d.fmt     = req.fmt;
    mid_d.special = 1'b1;                   // Cleared on the rounding paths
    if (req.nan_a || req.nan_b)
    begin
      mid_d.sign     = 1'b0;                // Canonical NaN
      mid_d.mant     = QNAN_MANT;
      mid_d.exp      = '1;
      mid_d.flags.nv = req.snan;
    end
    else if (req.inf_a)
    begin
      mid_d.exp = '1;
      if (is_div && req.inf_b)
      begin
        mid_d.sign     = 1'b0;             // inf/inf
        mid_d.mant     = QNAN_MANT;
        mid_d.flags.nv = 1'b1;
      end
      else
        mid_d.flags.of = 1'b1;             // Signed infinity
    end
    else if (is_div && req.inf_b)
      mid_d.exp = '0;                       // x/inf gives signed zero
    else if (req.zero_a)
    begin
      if (is_div && req.zero_b)
      begin
        mid_d.sign     = 1'b0;             // 0/0
        mid_d.mant     = QNAN_MANT;
        mid_d.exp      = '1;
        mid_d.flags.nv = 1'b1;
      end
    end
    else if (is_div && req.zero_b)
    begin
      mid_d.exp      = '1;                  // x/0
      mid_d.flags.dz = 1'b1;
    end
    else if (is_sqrt && req.sign)
    begin
      mid_d.sign     = 1'b0;                // Root of a negative value
      mid_d.mant     = QNAN_MANT;
      mid_d.exp      = '1;
      mid_d.flags.nv = 1'b1;
    end
    else if (denorm)
    begin
      mid_d.flags.uf = 1'b1;
      // Whole significand shifted out
      if (rs_count > sig_w)
        mid_d.flags.nx = 1'b1;              // Flush to signed zero
      else
      begin
        mid_d.special                  = 1'b0;
        {mid_d.mant, mid_d.round_bits} = rs_vec;
        mid_d.exp                      = '0;
      end
    end
    else if (req.exp >= exp_max)
    begin
      mid_d.exp      = '1;                  // Overflow to infinity
      mid_d.flags.of = 1'b1;
      mid_d.flags.nx = 1'b1;
    end
    else
    begin
      mid_d.special                  = 1'b0;
      {mid_d.mant, mid_d.round_bits} = norm_vec;
      // 0.1x form drops one from the exponent
      mid_d.exp = top_bit ? exp_t'(req.exp) : exp_t'(exp_dec);
    end
  end

  //////////////////////////////////////////////////
  // Pipeline register

  always_ff @(posedge clk)
  begin
    if (rst)
      mid_valid <= 1'b0;
    else
      mid_valid <= in_valid;
  end

  // Payload only moves with a request
  always_ff @(posedge clk)
  begin
    if (in_valid)
      mid <= mid_d;
  end

endmodule

/* design/round_unit.sv */
//////////////////////////////////////////////////
// Stage two of normalize and round
// Rounds at the format LSB and renormalizes on carry
// FP16 results are NaN-boxed into 32 bits
// One cycle latency, output must be taken when valid
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "norm_defines.svh"

module round_unit
  import norm_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      mid_valid,
  input  norm_mid_t mid,
  output logic      out_valid,
  output flen_t     result,
  output fflags_t   fflags
);

  localparam int   MANT_W    = $bits(mant_t);
  localparam int   RB_W      = $bits(round_bits_t);
  localparam int   EXP_W     = $bits(exp_t);
  localparam int   FP16_LSB  = `NORM_FP16_LSB;
  localparam exp_t EXP_FP32  = exp_t'(2**`NORM_EXP_FP32 - 1);
  localparam exp_t EXP_FP16  = exp_t'(2**`NORM_EXP_FP16 - 1);

  mant_t          upper;       // Kept bits, low part cleared
  mant_t          inc_vec;     // One at the format LSB
  logic           lsb;
  logic           guard;
  logic           sticky;
  logic           inexact;
  logic           round_up;
  exp_t           exp_max;
  logic [MANT_W:0] sum;
  logic           carry;
  logic           promote;     // Denormal rounded up to the smallest normal
  mant_t          mant_rnd;
  logic [EXP_W:0] exp_rnd;
  logic           ovf;
  mant_t          mant_fin;
  exp_t           exp_fin;
  flen_t          result_d;
  fflags_t        fflags_d;

  //////////////////////////////////////////////////
  // Guard and sticky per format

  always_comb
  begin
    if (mid.fmt == FMT_FP32)
    begin
      upper   = mid.mant;
      inc_vec = mant_t'(1);
      lsb     = mid.mant[0];
      guard   = mid.round_bits[RB_W-1];
      sticky  = |mid.round_bits[RB_W-2:0];
      exp_max = EXP_FP32;
    end
    else
    begin
      upper   = {mid.mant[MANT_W-1:FP16_LSB], {FP16_LSB{1'b0}}};
      inc_vec = mant_t'(1) << FP16_LSB;
      lsb     = mid.mant[FP16_LSB];
      guard   = mid.mant[FP16_LSB-1];
      sticky  = (|mid.mant[FP16_LSB-2:0]) | (|mid.round_bits);
      exp_max = EXP_FP16;
    end
  end

  assign inexact = guard | sticky;

  // Round-up decision
  always_comb
  begin
    case (mid.rm)
      RM_RNE:  round_up = guard & (sticky | lsb);  // Ties to even
      RM_RUP:  round_up = inexact & ~mid.sign;
      RM_RDN:  round_up = inexact & mid.sign;
      default: round_up = 1'b0;                    // RTZ and unknown codes
    endcase
  end

  //////////////////////////////////////////////////
  // Add, renormalize, overflow

  assign sum      = {1'b0, upper} + (round_up ? {1'b0, inc_vec} : '0);
  assign carry    = sum[MANT_W];
  assign promote  = (mid.exp == '0) && sum[MANT_W-1];
  assign mant_rnd = carry ? sum[MANT_W:1] : sum[MANT_W-1:0];
  assign exp_rnd  = {1'b0, mid.exp} + (EXP_W+1)'(carry | promote);
  assign ovf      = (exp_rnd >= {1'b0, exp_max});  // Carry hit all ones

  always_comb
  begin
    fflags_d = mid.flags;
    if (mid.special)
    begin
      mant_fin = mid.mant;                         // Packed in stage one
      exp_fin  = mid.exp;
    end
    else if (ovf)
    begin
      mant_fin    = '0;                            // Infinity
      exp_fin     = '1;
      fflags_d.of = 1'b1;
      fflags_d.nx = 1'b1;
    end
    else
    begin
      mant_fin    = mant_rnd;
      exp_fin     = exp_rnd[EXP_W-1:0];
      fflags_d.nx = mid.flags.nx | inexact;
    end
  end

  // Pack and box
  always_comb
  begin
    if (mid.fmt == FMT_FP32)
      result_d = {mid.sign, exp_fin, mant_fin[MANT_W-2:0]};
    else
      result_d = {`NORM_BOX_FILL, mid.sign, exp_fin[`NORM_EXP_FP16-1:0],
                  mant_fin[MANT_W-2:FP16_LSB]};
  end

  //////////////////////////////////////////////////
  // Output register

  always_ff @(posedge clk)
  begin
    if (rst)
      out_valid <= 1'b0;
    else
      out_valid <= mid_valid;
  end

  always_ff @(posedge clk)
  begin
    if (mid_valid)
    begin
      result <= result_d;
      fflags <= fflags_d;
    end
  end

endmodule

/* design/norm_round_top.sv */
//////////////////////////////////////////////////
// Normalize and round back end for divide/sqrt
// in_valid at edge N gives out_valid at edge N+2
// Accepts one request per cycle with no back-pressure
//////////////////////////////////////////////////

`timescale 1ns/1ps

module norm_round_top
  import norm_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      in_valid,
  input  norm_req_t req,       // Sampled with in_valid
  output logic      out_valid,
  output flen_t     result,
  output fflags_t   fflags
);

  // Stage one to stage two
  logic      mid_valid;
  norm_mid_t mid;

  //////////////////////////////////////////////////
  // Special cases and normalization

  special_case_norm special_case_norm_i (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .req       (req),
    .mid_valid (mid_valid),
    .mid       (mid)
  );

  //////////////////////////////////////////////////
  // Rounding and packing

  round_unit round_unit_i (
    .clk       (clk),
    .rst       (rst),
    .mid_valid (mid_valid),
    .mid       (mid),
    .out_valid (out_valid),
    .result    (result),
    .fflags    (fflags)
  );

endmodule

/* verif/tb_norm_round.sv */
//////////////////////////////////////////////////
// Directed testbench for the normalize and round back end
// Expected results come from a model of the result rules
// Monitor expects each result exactly two edges after its request
// Random stimulus uses a fixed seed
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "norm_defines.svh"

module tb_norm_round
  import norm_pkg::*;
;

  localparam int CLK_PERIOD = 40;
  localparam int RAND_N     = 8;    // Random significands per mode and sign
  localparam int THRU_N     = 64;   // Back-to-back requests
  // Requests over all tests
  localparam int REQ_TOTAL  = 22 + 10 + 16 * RAND_N + 8 + 14 + 10 + THRU_N;
  // Margin covers reset and the drain after each test
  localparam int WATCHDOG_NS = (REQ_TOTAL + 100) * CLK_PERIOD;

  typedef struct packed {
    flen_t   result;
    fflags_t flags;
  } resp_t;

  logic      clk;
  logic      rst;
  logic      in_valid;
  norm_req_t req;
  logic      out_valid;
  flen_t     result;
  fflags_t   fflags;

  int    cyc = 0;         // Rising edges so far
  int    err_count;
  int    tests_run;
  int    tests_failed;
  resp_t exp_q[$];        // Expected responses in issue order
  int    issue_q[$];
  string tag_q[$];
  resp_t mon_want;
  int    mon_issue;
  string mon_tag;

  norm_round_top norm_round_top_i (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .req       (req),
    .out_valid (out_valid),
    .result    (result),
    .fflags    (fflags)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk)
    cyc <= cyc + 1;

  // Watchdog
  initial
  begin
    #(WATCHDOG_NS);
    $display("Timeout after %0d ns with %0d results outstanding", WATCHDOG_NS, exp_q.size());
    $display("sim failed");
    $finish;
  end

  //////////////////////////////////////////////////
  // Compare tasks

  task automatic check_result(input flen_t got, input flen_t want, input string tag);
    if (got !== want)
    begin
      $display("Mismatch at %0t: %s result %h, expected %h", $time, tag, got, want);
      err_count++;
    end
  endtask

  task automatic check_fflags(input fflags_t got, input fflags_t want, input string tag);
    if (got !== want)
    begin
      $display("Mismatch at %0t: %s flags %b, expected %b", $time, tag, got, want);
      err_count++;
    end
  endtask

  //////////////////////////////////////////////////
  // Reference model

  function automatic flen_t pack_fp(input fmt_e fmt, input logic sign, input int expo,
                                    input logic [63:0] frac);
    logic [31:0] e_bits;
    e_bits = expo;
    if (fmt == FMT_FP32)
      return {sign, e_bits[`NORM_EXP_FP32-1:0], frac[`NORM_MANT_FP32-1:0]};
    else
      return {`NORM_BOX_FILL, sign, e_bits[`NORM_EXP_FP16-1:0], frac[`NORM_MANT_FP16-1:0]};
  endfunction

  function automatic resp_t ref_model(input norm_req_t r);
    resp_t       o;
    fflags_t     f;
    int          frac_w;
    int          ones;
    int          e;
    int          shift;
    logic [63:0] ext;      // Bit 63 weighs 1.0
    logic [63:0] kept;
    logic [63:0] rem;
    logic [63:0] qnan;
    logic        top;
    logic        div;
    logic        denorm;
    logic        guard;
    logic        sticky;
    logic        up;
    frac_w = (r.fmt == FMT_FP32) ? `NORM_MANT_FP32 : `NORM_MANT_FP16;
    ones   = (r.fmt == FMT_FP32) ? (1 << `NORM_EXP_FP32) - 1 : (1 << `NORM_EXP_FP16) - 1;
    qnan   = 64'd1 << (frac_w - 1);
    div    = (r.op == OP_DIV);
    top    = r.mant[$bits(mant_in_t)-1];
    e      = int'($signed(r.exp));
    denorm = (e <= 0) || ((e == 1) && !top);
    shift  = 1 - e;                              // Right shift down to exponent 0
    f      = '0;
    if (r.nan_a || r.nan_b)
    begin
      o.result = pack_fp(r.fmt, 1'b0, ones, qnan);
      f.nv     = r.snan;
    end
    else if (r.inf_a && div && r.inf_b)
    begin
      o.result = pack_fp(r.fmt, 1'b0, ones, qnan);
      f.nv     = 1'b1;
    end
    else if (r.inf_a)
    begin
      o.result = pack_fp(r.fmt, r.sign, ones, 64'd0);
      f.of     = 1'b1;
    end
    else if (div && r.inf_b)
      o.result = pack_fp(r.fmt, r.sign, 0, 64'd0);
    else if (r.zero_a && div && r.zero_b)
    begin
      o.result = pack_fp(r.fmt, 1'b0, ones, qnan);
      f.nv     = 1'b1;
    end
    else if (r.zero_a)
      o.result = pack_fp(r.fmt, r.sign, 0, 64'd0);
    else if (div && r.zero_b)
    begin
      o.result = pack_fp(r.fmt, r.sign, ones, 64'd0);
      f.dz     = 1'b1;
    end
    else if (!div && r.sign)
    begin
      o.result = pack_fp(r.fmt, 1'b0, ones, qnan);
      f.nv     = 1'b1;
    end
    else if (denorm && (shift > frac_w + 1))
    begin
      o.result = pack_fp(r.fmt, r.sign, 0, 64'd0);  // Everything shifted out
      f.uf     = 1'b1;
      f.nx     = 1'b1;
    end
    else if (e >= ones)
    begin
      o.result = pack_fp(r.fmt, r.sign, ones, 64'd0);
      f.of     = 1'b1;
      f.nx     = 1'b1;
    end
    else
    begin
      ext = {r.mant, 36'b0};
      if (denorm)
      begin
        ext  = ext >> shift;
        e    = 0;
        f.uf = 1'b1;
      end
      else if (!top)
      begin
        ext = ext << 1;                            // 0.1x form
        e   = e - 1;
      end
      kept   = ext >> (63 - frac_w);               // Hidden bit plus fraction
      rem    = ext << (frac_w + 1);
      guard  = rem[63];
      sticky = |rem[62:0];
      case (r.rm)
        RM_RNE:  up = guard && (sticky || kept[0]);
        RM_RUP:  up = (guard || sticky) && !r.sign;
        RM_RDN:  up = (guard || sticky) && r.sign;
        default: up = 1'b0;
      endcase
      kept = kept + up;
      if (kept[frac_w+1])
      begin
        kept = kept >> 1;                          // Carry-out renormalizes
        e    = e + 1;
      end
      if ((e == 0) && kept[frac_w])
        e = 1;                                     // Denormal became normal
      f.nx = guard || sticky;
      if (e >= ones)
      begin
        o.result = pack_fp(r.fmt, r.sign, ones, 64'd0);
        f.of     = 1'b1;
        f.nx     = 1'b1;
      end
      else
        o.result = pack_fp(r.fmt, r.sign, e, kept);
    end
    o.flags = f;
    return o;
  endfunction

  //////////////////////////////////////////////////
  // Driving and monitoring

  function automatic norm_req_t make_req(input mant_in_t mant, input int expo, input logic sign,
                                         input rm_e rm, input fmt_e fmt);
    norm_req_t r;
    r      = '0;
    r.mant = mant;
    r.exp  = exp_in_t'(expo);
    r.sign = sign;
    r.op   = OP_DIV;
    r.rm   = rm;
    r.fmt  = fmt;
    return r;
  endfunction

  // Class bits in order nan_a, nan_b, snan, inf_a, inf_b, zero_a, zero_b
  function automatic norm_req_t set_class(input norm_req_t base, input logic [6:0] cls,
                                          input op_e op);
    norm_req_t r;
    r  = base;
    {r.nan_a, r.nan_b, r.snan, r.inf_a, r.inf_b, r.zero_a, r.zero_b} = cls;
    r.op = op;
    return r;
  endfunction

  task automatic send_req(input norm_req_t r, input string tag);
    string fmt_name;
    fmt_name = (r.fmt == FMT_FP32) ? "FP32" : "FP16";
    @(posedge clk);
    #2;
    req      = r;
    in_valid = 1'b1;
    exp_q.push_back(ref_model(r));
    issue_q.push_back(cyc);
    tag_q.push_back({fmt_name, " ", tag});
  endtask

  // Idle the input and wait for every result
  task automatic drain_pipe();
    @(posedge clk);
    #2;
    in_valid = 1'b0;
    while (exp_q.size() > 0)
      @(negedge clk);
    @(negedge clk);                                // Catch a stray out_valid
  endtask

  always @(negedge clk)
  begin
    if (!rst)
    begin
      if (out_valid === 1'b1)
      begin
        if (exp_q.size() == 0)
        begin
          $display("Error at %0t: out_valid high with no request pending", $time);
          err_count++;
        end
        else
        begin
          mon_want  = exp_q.pop_front();
          mon_issue = issue_q.pop_front();
          mon_tag   = tag_q.pop_front();
          if (cyc != mon_issue + 2)
          begin
            $display("Error at %0t: %s arrived %0d cycles after its request instead of 2",
                     $time, mon_tag, cyc - mon_issue);
            err_count++;
          end
          check_result(result, mon_want.result, mon_tag);
          check_fflags(fflags, mon_want.flags, mon_tag);
        end
      end
      else if (out_valid !== 1'b0)
      begin
        $display("Error at %0t: out_valid is unknown", $time);
        err_count++;
      end
      else if ((issue_q.size() > 0) && (cyc >= issue_q[0] + 2))
      begin
        mon_want  = exp_q.pop_front();
        mon_issue = issue_q.pop_front();
        mon_tag   = tag_q.pop_front();
        $display("Error at %0t: out_valid missing for %s", $time, mon_tag);
        err_count++;
      end
    end
  end

  task automatic report_test(input string name, input int err_before);
    tests_run++;
    if (err_count == err_before)
      $display("%-12s done, no errors", name);
    else
    begin
      tests_failed++;
      $display("%-12s done, %0d errors", name, err_count - err_before);
    end
  endtask

  //////////////////////////////////////////////////
  // Directed tests

  task automatic run_specials();
    norm_req_t neg;
    norm_req_t pos;
    int        err0;
    int        k;
    err0 = err_count;
    for (k = 0; k < 2; k++)
    begin
      neg      = make_req({1'b1, 27'h2ab_cdef}, 20, 1'b1, RM_RNE, fmt_e'(k));
      pos      = neg;
      pos.sign = 1'b0;
      send_req(set_class(neg, 7'b100_0000, OP_DIV), "qnan a");
      send_req(set_class(neg, 7'b011_0000, OP_DIV), "snan b");
      send_req(set_class(neg, 7'b000_1100, OP_DIV), "inf/inf");
      send_req(set_class(neg, 7'b000_1000, OP_DIV), "inf/x");
      send_req(set_class(neg, 7'b000_0100, OP_DIV), "x/inf");
      send_req(set_class(neg, 7'b000_0011, OP_DIV), "0/0");
      send_req(set_class(neg, 7'b000_0010, OP_DIV), "0/x");
      send_req(set_class(neg, 7'b000_0001, OP_DIV), "x/0");
      send_req(set_class(neg, 7'b000_0000, OP_SQRT), "sqrt neg");
      send_req(set_class(neg, 7'b000_0010, OP_SQRT), "sqrt -0");
      send_req(set_class(pos, 7'b000_1000, OP_SQRT), "sqrt inf");
    end
    drain_pipe();
    report_test("specials", err0);
  endtask

  task automatic normal_values();
    int err0;
    err0 = err_count;
    send_req(make_req({1'b1, 23'h123456, 4'h0}, 127, 1'b0, RM_RNE, FMT_FP32), "1.x");
    send_req(make_req({2'b01, 23'h654321, 3'h0}, 127, 1'b1, RM_RNE, FMT_FP32), "0.1x");
    send_req(make_req({1'b1, 23'h7fffff, 4'h0}, 254, 1'b0, RM_RNE, FMT_FP32), "max");
    send_req(make_req({2'b01, 23'h00ff00, 3'h0}, 254, 1'b0, RM_RNE, FMT_FP32), "0.1x top");
    send_req(make_req({1'b1, 23'h000001, 4'h0}, 1, 1'b1, RM_RNE, FMT_FP32), "min normal");
    send_req(make_req({1'b1, 10'h2a5, 17'h0}, 15, 1'b0, RM_RNE, FMT_FP16), "1.x");
    send_req(make_req({2'b01, 10'h15a, 16'h0}, 15, 1'b1, RM_RNE, FMT_FP16), "0.1x");
    send_req(make_req({1'b1, 10'h3ff, 17'h0}, 30, 1'b0, RM_RNE, FMT_FP16), "max");
    send_req(make_req({2'b01, 10'h0f0, 16'h0}, 30, 1'b1, RM_RNE, FMT_FP16), "0.1x top");
    send_req(make_req({1'b1, 10'h001, 17'h0}, 1, 1'b0, RM_RNE, FMT_FP16), "min normal");
    drain_pipe();
    report_test("normals", err0);
  endtask

  task automatic rounding_modes();
    rm_e      modes[4];
    mant_in_t sigs[RAND_N];
    int       err0;
    int       k;
    int       m;
    int       s;
    int       i;
    err0  = err_count;
    modes = '{RM_RNE, RM_RTZ, RM_RUP, RM_RDN};
    for (i = 0; i < RAND_N; i++)
      sigs[i] = {1'b1, 27'($urandom)} | mant_in_t'(1);  // Low bits never all zero
    for (k = 0; k < 2; k++)
      for (m = 0; m < 4; m++)
        for (s = 0; s < 2; s++)
          for (i = 0; i < RAND_N; i++)
            send_req(make_req(sigs[i], (k == 0) ? 127 : 15, s[0], modes[m], fmt_e'(k)),
                     $sformatf("random rm %0d sign %0d", m, s));
    // Ties to even in both directions
    send_req(make_req({1'b1, 23'h000002, 4'h8}, 127, 1'b0, RM_RNE, FMT_FP32), "tie even");
    send_req(make_req({1'b1, 23'h000003, 4'h8}, 127, 1'b0, RM_RNE, FMT_FP32), "tie odd");
    send_req(make_req({1'b1, 10'h002, 1'b1, 16'h0}, 15, 1'b1, RM_RNE, FMT_FP16), "tie even");
    send_req(make_req({1'b1, 10'h003, 1'b1, 16'h0}, 15, 1'b1, RM_RNE, FMT_FP16), "tie odd");
    // All ones carries out of the significand
    send_req(make_req(28'hfff_ffff, 127, 1'b0, RM_RNE, FMT_FP32), "carry rne");
    send_req(make_req(28'hfff_ffff, 127, 1'b1, RM_RDN, FMT_FP32), "carry rdn");
    send_req(make_req(28'hfff_ffff, 15, 1'b0, RM_RUP, FMT_FP16), "carry rup");
    send_req(make_req(28'hfff_ffff, 15, 1'b0, RM_RTZ, FMT_FP16), "no carry rtz");
    drain_pipe();
    report_test("rounding", err0);
  endtask

  task automatic denormals();
    int err0;
    err0 = err_count;
    send_req(make_req(28'h800_0000, 0, 1'b0, RM_RNE, FMT_FP32), "exact exp 0");
    send_req(make_req(28'hc00_0010, 0, 1'b1, RM_RNE, FMT_FP32), "exp 0");
    send_req(make_req(28'h600_0008, 1, 1'b0, RM_RNE, FMT_FP32), "exp 1 0.1x");
    send_req(make_req(28'h9ab_cdef, -3, 1'b0, RM_RTZ, FMT_FP32), "exp -3");
    send_req(make_req(28'h9ab_cdef, -20, 1'b0, RM_RUP, FMT_FP32), "exp -20");
    send_req(make_req(28'hfff_ffff, -23, 1'b0, RM_RNE, FMT_FP32), "shift 24");
    send_req(make_req(28'hfff_ffff, 0, 1'b0, RM_RNE, FMT_FP32), "to min normal");
    send_req(make_req(28'h9ab_cdef, -30, 1'b1, RM_RNE, FMT_FP32), "flush");
    send_req(make_req(28'hc00_0000, 0, 1'b0, RM_RNE, FMT_FP16), "exp 0");
    send_req(make_req(28'h600_0000, 1, 1'b1, RM_RNE, FMT_FP16), "exp 1 0.1x");
    send_req(make_req(28'h9ab_cdef, -5, 1'b0, RM_RDN, FMT_FP16), "exp -5");
    send_req(make_req(28'hfff_ffff, -9, 1'b1, RM_RDN, FMT_FP16), "shift 10");
    send_req(make_req(28'hfff_ffff, 0, 1'b0, RM_RNE, FMT_FP16), "to min normal");
    send_req(make_req(28'h9ab_cdef, -12, 1'b0, RM_RNE, FMT_FP16), "flush");
    drain_pipe();
    report_test("denormals", err0);
  endtask

  task automatic overflows();
    int err0;
    err0 = err_count;
    send_req(make_req(28'h9ab_cdef, 255, 1'b0, RM_RNE, FMT_FP32), "exp 255");
    send_req(make_req(28'h4ab_cdef, 255, 1'b1, RM_RNE, FMT_FP32), "exp 255 0.1x");
    send_req(make_req(28'h9ab_cdef, 300, 1'b1, RM_RTZ, FMT_FP32), "exp 300");
    send_req(make_req(28'hfff_ffff, 254, 1'b0, RM_RNE, FMT_FP32), "round carry");
    send_req(make_req(28'hfff_ffff, 254, 1'b1, RM_RUP, FMT_FP32), "no carry rup neg");
    send_req(make_req(28'h9ab_cdef, 31, 1'b0, RM_RNE, FMT_FP16), "exp 31");
    send_req(make_req(28'h4ab_cdef, 31, 1'b1, RM_RNE, FMT_FP16), "exp 31 0.1x");
    send_req(make_req(28'h9ab_cdef, 40, 1'b0, RM_RDN, FMT_FP16), "exp 40");
    send_req(make_req(28'hfff_ffff, 30, 1'b1, RM_RNE, FMT_FP16), "round carry");
    send_req(make_req(28'hfff_ffff, 30, 1'b0, RM_RTZ, FMT_FP16), "no carry rtz");
    drain_pipe();
    report_test("overflows", err0);
  endtask

  task automatic back_to_back();
    norm_req_t r;
    mant_in_t  mant;
    int        err0;
    int        i;
    err0 = err_count;
    for (i = 0; i < THRU_N; i++)
    begin
      mant = mant_in_t'($urandom);
      if (!mant[27])
        mant[26] = 1'b1;                           // Keep the 0.1x form
      if ($urandom_range(0, 1) == 0)
        r = make_req(mant, int'($urandom_range(0, 260)) - 3, 1'($urandom), RM_RNE, FMT_FP32);
      else
        r = make_req(mant, int'($urandom_range(0, 36)) - 3, 1'($urandom), RM_RNE, FMT_FP16);
      r.rm = rm_e'($urandom_range(0, 3));
      r.op = op_e'($urandom_range(0, 1));
      if ($urandom_range(0, 7) == 0)
        r.zero_b = 1'b1;                           // Occasional x/0
      send_req(r, $sformatf("burst %0d", i));
    end
    drain_pipe();
    report_test("throughput", err0);
  endtask

  //////////////////////////////////////////////////
  // Main sequence

  initial
  begin
    rst          = 1'b1;
    in_valid     = 1'b0;
    req          = '0;
    err_count    = 0;
    tests_run    = 0;
    tests_failed = 0;
    void'($urandom(32'hc68b_af06));
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;
    @(negedge clk);
    if (out_valid !== 1'b0)
    begin
      $display("Error at %0t: out_valid not low after reset", $time);
      err_count++;
    end
    run_specials();
    normal_values();
    rounding_modes();
    denormals();
    overflows();
    back_to_back();
    $display("Summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
             err_count);
    if (err_count == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

/* files.f */
+incdir+include
design/norm_pkg.sv
design/special_case_norm.sv
design/round_unit.sv
design/norm_round_top.sv
verif/tb_norm_round.sv

/* Bender.yml */
package:
  name: norm_round

export_include_dirs:
  - include

sources:
  - design/norm_pkg.sv
  - design/special_case_norm.sv
  - design/round_unit.sv
  - design/norm_round_top.sv
  - target: test
    files:
      - verif/tb_norm_round.sv
